// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_uart_alu
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: alu.sv
`timescale 1ns/100ps

module alu
(
	input  alu_uart_pkg::alu_operands_t operands,
	output alu_uart_pkg::byte_t         result
);

	// shift amount, only low 3 bits of b
	logic [2:0] shamt;

	assign shamt = operands.b[2:0];

	always_comb
	begin
		case (operands.op)
			// add and sub wrap at 8 bits
			alu_uart_pkg::OP_ADD:
				result = operands.a + operands.b;
			alu_uart_pkg::OP_SUB:
				result = operands.a - operands.b;
			// bitwise group
			alu_uart_pkg::OP_AND:
				result = operands.a & operands.b;
			alu_uart_pkg::OP_OR:
				result = operands.a | operands.b;
			alu_uart_pkg::OP_XOR:
				result = operands.a ^ operands.b;
			alu_uart_pkg::OP_NOR:
				result = ~(operands.a | operands.b);
			// sign fill from bit 7
			alu_uart_pkg::OP_SRA:
				result = alu_uart_pkg::byte_t'($signed(operands.a) >>> shamt);
			alu_uart_pkg::OP_SRL:
				result = operands.a >> shamt;
			// undefined opcode gives zero
			default:
				result = '0;
		endcase
	end

endmodule

// File: alu_uart_pkg.sv
package alu_uart_pkg;

	////////////////////
	// serial frame format
	////////////////////

	// ticks per bit on the line
	parameter int OVERSAMPLE = 16;
	// data bits per frame, no parity, one stop bit
	parameter int DATA_BITS = 8;
	// opcode bits taken from the third byte
	parameter int OP_BITS = 6;

	// one byte on the wire, also operand and result width
	typedef logic [DATA_BITS-1:0] byte_t;

	////////////////////
	// alu opcodes
	////////////////////

	typedef enum logic [OP_BITS-1:0] {
		OP_ADD = 6'h20,
		OP_SUB = 6'h22,
		OP_AND = 6'h24,
		OP_OR  = 6'h25,
		OP_XOR = 6'h26,
		OP_NOR = 6'h27,
		OP_SRA = 6'h03,
		OP_SRL = 6'h02
	} alu_op_e;

	// operand triple, link to alu
	typedef struct packed {
		byte_t   a;
		byte_t   b;
		alu_op_e op;
	} alu_operands_t;

	// link fsm, kept here so the checkers can name it
	typedef enum logic [1:0] {
		WAIT_A,
		WAIT_B,
		WAIT_OP,
		SEND_RESULT
	} link_state_e;

endpackage

// File: baud_gen.sv
`timescale 1ns/100ps

module baud_gen
#(
	parameter int BAUD_DIV = 163
)
(
	input  logic clk,
	input  logic rst,
	output logic tick
);

	// counter wide enough for BAUD_DIV - 1, never zero bits
	localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BAUD_DIV - 1);

	logic [CNT_W-1:0] cnt;

	// wrapping divider, tick high for one clk per period
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else if (cnt == CNT_LAST)
		begin
			cnt  <= '0;
			tick <= 1'b1;
		end
		else
		begin
			cnt  <= cnt + CNT_W'(1);
			tick <= 1'b0;
		end
	end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk,
	output logic rst
);

	// 25 MHz bench clock
	localparam time HALF_PERIOD = 20ns;
	localparam int RST_CYCLES = 3;

	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_PERIOD) clk = ~clk;
	end

	// reset held over the first rising edges, released on a falling edge
	initial
	begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: tb_uart_alu.sv
`timescale 1ns/100ps

module tb_uart_alu;

	localparam int BAUD_DIV = 2;
	// clocks per serial bit
	localparam int BIT_CLKS = BAUD_DIV * alu_uart_pkg::OVERSAMPLE;
	// covers three request frames and the reply start
	localparam int REPLY_TIMEOUT = 50 * BIT_CLKS;
	localparam int RST_TIMEOUT = 100;
	localparam alu_uart_pkg::alu_op_e OP_TABLE [8] = '{
		alu_uart_pkg::OP_ADD, alu_uart_pkg::OP_SUB, alu_uart_pkg::OP_AND, alu_uart_pkg::OP_OR,
		alu_uart_pkg::OP_XOR, alu_uart_pkg::OP_NOR, alu_uart_pkg::OP_SRA, alu_uart_pkg::OP_SRL
	};

	logic clk;
	logic rst;
	logic rx;
	logic tx;
	// galois lfsr state
	logic [15:0] lfsr_state = 16'd19687;

	tb_clock_gen u_clk (
		.clk(clk),
		.rst(rst)
	);

	uart_alu_top #(
		.BAUD_DIV(BAUD_DIV)
	) UUT (
		.clk(clk),
		.rst(rst),
		.rx (rx),
		.tx (tx)
	);

	////////////////////
	// reporting and compares
	////////////////////

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input alu_uart_pkg::byte_t got,
		input alu_uart_pkg::byte_t exp);
		if (got !== exp)
			stop_on_error($sformatf("error %s got 0x%02h expected 0x%02h", name, got, exp));
	endtask

	task automatic check_line(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("error %s got 0x%01h expected 0x%01h", name, got, exp));
	endtask

	////////////////////
	// reference model and lfsr
	////////////////////

	// expected reply from the opcode rules
	function automatic alu_uart_pkg::byte_t model_result(input alu_uart_pkg::byte_t a,
		input alu_uart_pkg::byte_t b, input alu_uart_pkg::byte_t op_byte);
		logic [5:0] op;
		alu_uart_pkg::byte_t r;
		int amount;
		int i;
		op = op_byte[5:0];
		amount = {29'd0, b[2:0]};
		r = a;
		case (op)
			alu_uart_pkg::OP_ADD: r = a + b;
			alu_uart_pkg::OP_SUB: r = a - b;
			alu_uart_pkg::OP_AND: r = a & b;
			alu_uart_pkg::OP_OR:  r = a | b;
			alu_uart_pkg::OP_XOR: r = a ^ b;
			alu_uart_pkg::OP_NOR: r = ~(a | b);
			// sign bit copied on each step
			alu_uart_pkg::OP_SRA:
				for (i = 0; i < amount; i++)
					r = {r[7], r[7:1]};
			// zero filled
			alu_uart_pkg::OP_SRL:
				for (i = 0; i < amount; i++)
					r = {1'b0, r[7:1]};
			default: r = 8'h00;
		endcase
		return r;
	endfunction

	// taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int count, output alu_uart_pkg::byte_t value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[6:0], lfsr_state[0]};
		end
	endtask

	////////////////////
	// serial driver and monitor
	////////////////////

	// start bit then 8 data bits lsb first then stop bit
	// line moves on falling edges
	task automatic send_byte(input alu_uart_pkg::byte_t value);
		rx = 1'b0;
		repeat (BIT_CLKS) @(negedge clk);
		for (int i = 0; i < 8; i++)
		begin
			rx = value[i];
			repeat (BIT_CLKS) @(negedge clk);
		end
		rx = 1'b1;
		repeat (BIT_CLKS) @(negedge clk);
	endtask

	task automatic recv_byte(output alu_uart_pkg::byte_t value);
		int wait_cnt;
		wait_cnt = 0;
		value = '0;
		// start bit edge phase depends on the tick
		while (tx !== 1'b0)
		begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > REPLY_TIMEOUT)
				stop_on_error("timeout waiting for the reply start bit on tx");
		end
		repeat (BIT_CLKS / 2) @(negedge clk);
		check_line("tx start bit", tx, 1'b0);
		for (int i = 0; i < 8; i++)
		begin
			repeat (BIT_CLKS) @(negedge clk);
			value[i] = tx;
		end
		repeat (BIT_CLKS) @(negedge clk);
		check_line("tx stop bit", tx, 1'b1);
	endtask

	// reply starts inside the opcode stop bit
	task automatic run_triple(input alu_uart_pkg::byte_t a, input alu_uart_pkg::byte_t b,
		input alu_uart_pkg::byte_t op, input alu_uart_pkg::byte_t exp);
		alu_uart_pkg::byte_t got;
		fork
			begin
				send_byte(a);
				send_byte(b);
				send_byte(op);
			end
			recv_byte(got);
		join
		check_byte($sformatf("result a=%02h b=%02h op=%02h", a, b, op), got, exp);
		// idle gap while the link returns to WAIT_A
		repeat (BIT_CLKS) @(negedge clk);
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic idle_line_test();
		for (int i = 0; i < 200; i++)
		begin
			@(negedge clk);
			check_line("tx idle", tx, 1'b1);
		end
	endtask

	task automatic add_sub_test();
		run_triple(8'hF0, 8'h20, {2'b00, alu_uart_pkg::OP_ADD}, 8'h10);
		run_triple(8'h05, 8'h07, {2'b00, alu_uart_pkg::OP_SUB}, 8'hFE);
	endtask

	task automatic bitwise_test();
		alu_uart_pkg::byte_t op;
		for (int i = 2; i < 6; i++)
		begin
			op = {2'b00, OP_TABLE[i]};
			run_triple(8'hA5, 8'h3C, op, model_result(8'hA5, 8'h3C, op));
		end
	endtask

	// only the low 3 bits of b = 0x0B count
	task automatic shift_test();
		run_triple(8'h90, 8'h0B, {2'b00, alu_uart_pkg::OP_SRA}, 8'hF2);
		run_triple(8'h90, 8'h0B, {2'b00, alu_uart_pkg::OP_SRL}, 8'h12);
	endtask

	task automatic undefined_op_test();
		run_triple(8'h12, 8'h34, 8'h3F, 8'h00);
		// link must be collecting again
		run_triple(8'h12, 8'h34, {2'b00, alu_uart_pkg::OP_ADD}, 8'h46);
	endtask

	// fourth byte sent back to back lands while the reply is on tx
	task automatic busy_drop_test();
		alu_uart_pkg::byte_t got;
		fork
			begin
				send_byte(8'h21);
				send_byte(8'h43);
				send_byte({2'b00, alu_uart_pkg::OP_XOR});
				send_byte(8'hFF);
			end
			recv_byte(got);
		join
		check_byte("busy reply", got, 8'h62);
		repeat (BIT_CLKS) @(negedge clk);
		// stray byte must not have become operand a
		run_triple(8'h0F, 8'h01, {2'b00, alu_uart_pkg::OP_SUB}, 8'h0E);
	endtask

	task automatic random_sweep_test();
		alu_uart_pkg::byte_t a;
		alu_uart_pkg::byte_t b;
		alu_uart_pkg::byte_t idx;
		alu_uart_pkg::byte_t op;
		for (int n = 0; n < 20; n++)
		begin
			take_bits(8, a);
			take_bits(8, b);
			take_bits(3, idx);
			op = {2'b00, OP_TABLE[idx[2:0]]};
			run_triple(a, b, op, model_result(a, b, op));
		end
	endtask

	initial
	begin
		int rst_cnt;
		rx = 1'b1;
		rst_cnt = 0;
		@(negedge clk);
		while (rst !== 1'b0)
		begin
			@(negedge clk);
			rst_cnt++;
			if (rst_cnt > RST_TIMEOUT)
				stop_on_error("reset never released");
		end
		idle_line_test();
		add_sub_test();
		bitwise_test();
		shift_test();
		undefined_op_test();
		busy_drop_test();
		random_sweep_test();
		// failures caught by the bound assertions
		if (UUT.u_props.fail_count != 0)
		begin
			stop_on_error($sformatf("%0d bound assertion failures", UUT.u_props.fail_count));
		end
		else
		begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// File: uart_alu_link.sv
`timescale 1ns/100ps

module uart_alu_link
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        rx_done,
	input  logic                        tx_done,
	input  alu_uart_pkg::byte_t         rx_data,
	input  alu_uart_pkg::byte_t         result,
	output alu_uart_pkg::alu_operands_t operands,
	output logic                        tx_start,
	output alu_uart_pkg::byte_t         tx_data
);

	alu_uart_pkg::link_state_e state;
	// reply already launched in this SEND_RESULT visit
	logic                      sent;

	////////////////////
	// link fsm
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= alu_uart_pkg::WAIT_A;
			operands <= '0;
			tx_start <= 1'b0;
			sent     <= 1'b0;
		end
		else
		begin
			tx_start <= 1'b0;
			case (state)
				alu_uart_pkg::WAIT_A:
				begin
					if (rx_done)
					begin
						operands.a <= rx_data;
						state      <= alu_uart_pkg::WAIT_B;
					end
				end
				alu_uart_pkg::WAIT_B:
				begin
					if (rx_done)
					begin
						operands.b <= rx_data;
						state      <= alu_uart_pkg::WAIT_OP;
					end
				end
				alu_uart_pkg::WAIT_OP:
				begin
					// only the low opcode bits count
					if (rx_done)
					begin
						operands.op <= alu_uart_pkg::alu_op_e'(rx_data[alu_uart_pkg::OP_BITS-1:0]);
						state       <= alu_uart_pkg::SEND_RESULT;
					end
				end
				alu_uart_pkg::SEND_RESULT:
				begin
					// alu sees the whole triple from the first cycle here
					// incoming bytes are dropped until the reply is out
					if (!sent)
					begin
						tx_start <= 1'b1;
						sent     <= 1'b1;
					end
					else if (tx_done)
					begin
						sent  <= 1'b0;
						state <= alu_uart_pkg::WAIT_A;
					end
				end
				default:
				begin
					state <= alu_uart_pkg::WAIT_A;
				end
			endcase
		end
	end

	// reply byte, captured with the start pulse
	always_ff @(posedge clk)
	begin
		if (state == alu_uart_pkg::SEND_RESULT && !sent)
			tx_data <= result;
	end

endmodule

// File: uart_alu_properties.sv
`timescale 1ns/100ps

module uart_alu_properties
(
	input logic                        clk,
	input logic                        rst,
	input logic                        tx,
	input logic                        tx_start,
	input alu_uart_pkg::alu_operands_t operands,
	input alu_uart_pkg::link_state_e   state
);

	// failed assertion count, read back by the bench
	int fail_count = 0;

	////////////////////
	// line and handshake
	////////////////////

	// no reply in flight while collecting operand a
	idle_line: assert property (@(posedge clk) disable iff (rst)
		state == alu_uart_pkg::WAIT_A |-> tx)
	else
	begin
		fail_count = fail_count + 1;
		$error("tx low while link waits for operand a");
	end

	// start is a single-cycle pulse
	start_pulse: assert property (@(posedge clk) disable iff (rst)
		tx_start |=> !tx_start)
	else
	begin
		fail_count = fail_count + 1;
		$error("tx_start held longer than one cycle");
	end

	// registered pulse, one cycle after the fsm enters SEND_RESULT
	start_on_entry: assert property (@(posedge clk) disable iff (rst)
		tx_start |-> state == alu_uart_pkg::SEND_RESULT
			&& $past(state, 2) == alu_uart_pkg::WAIT_OP)
	else
	begin
		fail_count = fail_count + 1;
		$error("tx_start outside entry to SEND_RESULT");
	end

	// bytes arriving during the reply must not touch the operands
	operands_hold: assert property (@(posedge clk) disable iff (rst)
		state == alu_uart_pkg::SEND_RESULT && $past(state) == alu_uart_pkg::SEND_RESULT
			|-> $stable(operands))
	else
	begin
		fail_count = fail_count + 1;
		$error("operands changed during SEND_RESULT");
	end

endmodule

// attach to every top level instance
bind uart_alu_top uart_alu_properties u_props (
	.clk     (clk),
	.rst     (rst),
	.tx      (tx),
	.tx_start(tx_start),
	.operands(operands),
	.state   (u_link.state)
);

// File: uart_alu_top.sv
`timescale 1ns/100ps

module uart_alu_top
#(
	parameter int BAUD_DIV = 163
)
(
	input  logic clk,
	input  logic rst,
	input  logic rx,
	output logic tx
);

	logic                        tick;
	alu_uart_pkg::byte_t         rx_data;
	logic                        rx_done;
	alu_uart_pkg::alu_operands_t operands;
	alu_uart_pkg::byte_t         result;
	logic                        tx_start;
	alu_uart_pkg::byte_t         tx_data;
	logic                        tx_done;

	// shared 16x tick for both directions
	baud_gen #(
		.BAUD_DIV(BAUD_DIV)
	) u_baud (
		.clk (clk),
		.rst (rst),
		.tick(tick)
	);

	uart_rx u_rx (
		.clk (clk),
		.rst (rst),
		.tick(tick),
		.rx  (rx),
		.data(rx_data),
		.done(rx_done)
	);

	// byte collector and reply launcher
	uart_alu_link u_link (
		.clk     (clk),
		.rst     (rst),
		.rx_done (rx_done),
		.tx_done (tx_done),
		.rx_data (rx_data),
		.result  (result),
		.operands(operands),
		.tx_start(tx_start),
		.tx_data (tx_data)
	);

	alu u_alu (
		.operands(operands),
		.result  (result)
	);

	uart_tx u_tx (
		.clk  (clk),
		.rst  (rst),
		.tick (tick),
		.start(tx_start),
		.data (tx_data),
		.line (tx),
		.done (tx_done)
	);

endmodule

// File: uart_rx.sv
`timescale 1ns/100ps

module uart_rx
(
	input  logic                clk,
	input  logic                rst,
	input  logic                tick,
	input  logic                rx,
	output alu_uart_pkg::byte_t data,
	output logic                done
);

	localparam int TICK_W = $clog2(alu_uart_pkg::OVERSAMPLE);
	localparam int BIT_W  = $clog2(alu_uart_pkg::DATA_BITS);
	// half a bit, for the start check
	localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(alu_uart_pkg::OVERSAMPLE / 2 - 1);
	// full bit, from one mid-sample to the next
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(alu_uart_pkg::OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(alu_uart_pkg::DATA_BITS - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e           state;
	logic                rx_meta;
	logic                rx_sync;
	logic [TICK_W-1:0]   tick_cnt;
	logic [BIT_W-1:0]    bit_cnt;
	alu_uart_pkg::byte_t shift;

	////////////////////
	// input synchronizer
	////////////////////

	// two flops, reset to line idle level
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	////////////////////
	// frame fsm
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			done     <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					// falling edge, maybe a start bit
					if (!rx_sync)
					begin
						state    <= RX_START;
						tick_cnt <= '0;
					end
				end
				RX_START:
				begin
					if (tick)
					begin
						if (tick_cnt == TICK_MID)
						begin
							// still low at mid-bit, real start
							// glitch otherwise, drop it
							state    <= rx_sync ? RX_IDLE : RX_DATA;
							tick_cnt <= '0;
							bit_cnt  <= '0;
						end
						else
						begin
							tick_cnt <= tick_cnt + TICK_W'(1);
						end
					end
				end
				RX_DATA:
				begin
					if (tick)
					begin
						if (tick_cnt == TICK_LAST)
						begin
							tick_cnt <= '0;
							if (bit_cnt == BIT_LAST)
							begin
								state <= RX_STOP;
							end
							else
							begin
								bit_cnt <= bit_cnt + BIT_W'(1);
							end
						end
						else
						begin
							tick_cnt <= tick_cnt + TICK_W'(1);
						end
					end
				end
				RX_STOP:
				begin
					// mid stop bit, frame complete
					if (tick)
					begin
						if (tick_cnt == TICK_LAST)
						begin
							done  <= 1'b1;
							state <= RX_IDLE;
						end
						else
						begin
							tick_cnt <= tick_cnt + TICK_W'(1);
						end
					end
				end
				default:
				begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	////////////////////
	// data path
	////////////////////

	// lsb first, so shift in from the top
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && tick && tick_cnt == TICK_LAST)
		begin
			shift <= {rx_sync, shift[alu_uart_pkg::DATA_BITS-1:1]};
		end
		// output byte holds until the next frame ends
		if (state == RX_STOP && tick && tick_cnt == TICK_LAST)
		begin
			data <= shift;
		end
	end

endmodule

// File: uart_tx.sv
`timescale 1ns/100ps

module uart_tx
(
	input  logic                clk,
	input  logic                rst,
	input  logic                tick,
	input  logic                start,
	input  alu_uart_pkg::byte_t data,
	output logic                line,
	output logic                done
);

	localparam int TICK_W = $clog2(alu_uart_pkg::OVERSAMPLE);
	localparam int BIT_W  = $clog2(alu_uart_pkg::DATA_BITS);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(alu_uart_pkg::OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(alu_uart_pkg::DATA_BITS - 1);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_LOAD,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	tx_state_e           state;
	logic [TICK_W-1:0]   tick_cnt;
	logic [BIT_W-1:0]    bit_cnt;
	alu_uart_pkg::byte_t shift;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= TX_IDLE;
			line     <= 1'b1;
			done     <= 1'b0;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				TX_IDLE:
				begin
					// byte latched below, wait for tick
					if (start)
						state <= TX_LOAD;
				end
				TX_LOAD:
				begin
					// start bit lines up with a tick
					if (tick)
					begin
						line     <= 1'b0;
						tick_cnt <= '0;
						state    <= TX_START;
					end
				end
				TX_START:
				begin
					if (tick)
					begin
						if (tick_cnt == TICK_LAST)
						begin
							line     <= shift[0];
							tick_cnt <= '0;
							bit_cnt  <= '0;
							state    <= TX_DATA;
						end
						else
						begin
							tick_cnt <= tick_cnt + TICK_W'(1);
						end
					end
				end
				TX_DATA:
				begin
					if (tick)
					begin
						if (tick_cnt == TICK_LAST)
						begin
							tick_cnt <= '0;
							if (bit_cnt == BIT_LAST)
							begin
								// stop bit
								line  <= 1'b1;
								state <= TX_STOP;
							end
							else
							begin
								line    <= shift[1];
								bit_cnt <= bit_cnt + BIT_W'(1);
							end
						end
						else
						begin
							tick_cnt <= tick_cnt + TICK_W'(1);
						end
					end
				end
				TX_STOP:
				begin
					// end of stop bit, report and go idle
					if (tick)
					begin
						if (tick_cnt == TICK_LAST)
						begin
							done  <= 1'b1;
							state <= TX_IDLE;
						end
						else
						begin
							tick_cnt <= tick_cnt + TICK_W'(1);
						end
					end
				end
				default:
				begin
					line  <= 1'b1;
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// payload shifter, lsb goes out first
	always_ff @(posedge clk)
	begin
		if (state == TX_IDLE && start)
			shift <= data;
		else if (state == TX_DATA && tick && tick_cnt == TICK_LAST)
			shift <= {1'b0, shift[alu_uart_pkg::DATA_BITS-1:1]};
	end

endmodule

// File: vlog.f
alu_uart_pkg.sv
baud_gen.sv
uart_rx.sv
uart_tx.sv
alu.sv
uart_alu_link.sv
uart_alu_top.sv
uart_alu_properties.sv
tb_clock_gen.sv
tb_uart_alu.sv
